//--- logic/uart_pkg.sv
//**************************************************************************
// Frame format is fixed at 8N1. Only the bit length can change, and it is
// set by the BIT_TICKS parameter of the top level.
//**************************************************************************

`default_nettype none

package uart_pkg;

    // Data bits per frame, sent LSB first
    localparam int data_bits = 8;

    // Start bit, data bits and one stop bit
    localparam int frame_bits = data_bits + 2;

    // Line levels of the framing bits
    localparam logic start_bit = 1'b0;
    localparam logic stop_bit  = 1'b1;

    // 200 MHz / 173 gives about 1.156 Mbaud
    localparam int default_bit_ticks = 173;

    // Result of one received frame
    typedef struct packed {
        logic [data_bits-1:0] data;       // Received byte
        logic                 frame_err;  // Stop bit was sampled low
    } rx_word_t;

endpackage

`default_nettype wire

//--- logic/baud_strobe.sv
//**************************************************************************
// Free-running bit-rate strobe, one cycle high every BIT_TICKS cycles.
// BIT_TICKS must be 4 or more. The counter restarts on reset.
//**************************************************************************

`timescale 1ns/1ps
`default_nettype none

module baud_strobe #(
    parameter int BIT_TICKS = uart_pkg::default_bit_ticks
) (
    input  logic clk200,
    input  logic rst_n,
    output logic bit_strobe
);

    localparam int CNT_W = $clog2(BIT_TICKS);

    logic [CNT_W-1:0] tick_cnt;

    // Down-counter with reload, the strobe is registered from the zero state
    always_ff @(posedge clk200 or negedge rst_n) begin
        if (!rst_n) begin
            tick_cnt   <= CNT_W'(BIT_TICKS - 1);
            bit_strobe <= 1'b0;
        end else begin
            bit_strobe <= (tick_cnt == '0);
            if (tick_cnt == '0) begin
                tick_cnt <= CNT_W'(BIT_TICKS - 1);
            end else begin
                tick_cnt <= tick_cnt - 1'b1;
            end
        end
    end

    // The transmitter relies on a single-cycle strobe per bit period
    property p_strobe_single;
        @(posedge clk200) disable iff (!rst_n)
        bit_strobe |=> !bit_strobe;
    endproperty

    a_strobe_single : assert property (p_strobe_single)
        else $error("bit_strobe high on two consecutive cycles");

endmodule

`default_nettype wire

//--- logic/uart_tx.sv
//**************************************************************************
// 8N1 transmitter paced by an external bit strobe. A start pulse while busy
// is dropped, and the first bit waits for the next strobe.
//**************************************************************************

`timescale 1ns/1ps
`default_nettype none

module uart_tx (
    input  logic       clk200,
    input  logic       rst_n,
    input  logic       bit_strobe,
    input  logic       tx_start,
    input  logic [7:0] tx_data,
    output logic       tx_busy,
    output logic       txd
);

    localparam int CNT_W = $clog2(uart_pkg::frame_bits + 1);

    // Count value at the strobe that ends the stop bit
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(uart_pkg::frame_bits);

    logic [uart_pkg::frame_bits-1:0] shift_reg;  // Framed byte, LSB goes out first
    logic [CNT_W-1:0]                bit_cnt;
    logic                            accept;
    logic                            advance;

    assign accept  = tx_start && !tx_busy;
    assign advance = tx_busy && bit_strobe;

    // Control path, txd comes straight from this flop
    always_ff @(posedge clk200 or negedge rst_n) begin
        if (!rst_n) begin
            tx_busy <= 1'b0;
            txd     <= 1'b1;   // Idle line is high
            bit_cnt <= '0;
        end else if (accept) begin
            tx_busy <= 1'b1;
            bit_cnt <= '0;
        end else if (advance) begin
            if (bit_cnt == CNT_LAST) begin
                // Stop bit has run its full period, txd is already high
                tx_busy <= 1'b0;
            end else begin
                txd     <= shift_reg[0];
                bit_cnt <= bit_cnt + 1'b1;
            end
        end
    end

    // Frame data is captured on the accepted start and shifted once per bit
    always_ff @(posedge clk200) begin
        if (accept) begin
            shift_reg <= {uart_pkg::stop_bit, tx_data, uart_pkg::start_bit};
        end else if (advance) begin
            shift_reg <= shift_reg >> 1;
        end
    end

    property p_idle_high;
        @(posedge clk200) disable iff (!rst_n)
        !tx_busy |-> txd;
    endproperty

    // Busy may only drop on the strobe that closes the stop bit
    property p_busy_falls_on_strobe;
        @(posedge clk200) disable iff (!rst_n)
        (tx_busy && !bit_strobe) |=> tx_busy;
    endproperty

    a_idle_high : assert property (p_idle_high)
        else $error("txd low while tx_busy is low");

    a_busy_falls_on_strobe : assert property (p_busy_falls_on_strobe)
        else $error("tx_busy fell without a bit strobe");

endmodule

`default_nettype wire

//--- logic/uart_rx.sv
//**************************************************************************
// 8N1 receiver with its own bit timing. Samples at mid-bit, so the far end
// must be within a few percent of BIT_TICKS. rx_done must be caught.
//**************************************************************************

`timescale 1ns/1ps
`default_nettype none

module uart_rx #(
    parameter int BIT_TICKS = uart_pkg::default_bit_ticks
) (
    input  logic              clk200,
    input  logic              rst_n,
    input  logic              rxd,
    output logic              rx_busy,
    output logic              rx_done,
    output uart_pkg::rx_word_t rx_word
);

    localparam int CNT_W = $clog2(BIT_TICKS);
    localparam int IDX_W = $clog2(uart_pkg::data_bits);

    localparam logic [CNT_W-1:0] TICKS_HALF = CNT_W'(BIT_TICKS / 2 - 1);
    localparam logic [CNT_W-1:0] TICKS_FULL = CNT_W'(BIT_TICKS - 1);
    localparam logic [IDX_W-1:0] IDX_LAST   = IDX_W'(uart_pkg::data_bits - 1);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_START,
        ST_DATA,
        ST_STOP
    } rx_state_t;

    rx_state_t                      state;
    logic                           rxd_meta;
    logic                           rxd_sync;
    logic                           rxd_prev;
    logic                           start_edge;
    logic                           sample;
    logic [CNT_W-1:0]               tick_cnt;
    logic [IDX_W-1:0]               bit_idx;
    logic [uart_pkg::data_bits-1:0] data_sr;

    // Two-flop synchronizer plus one delay stage for the edge detector
    always_ff @(posedge clk200 or negedge rst_n) begin
        if (!rst_n) begin
            rxd_meta <= 1'b1;
            rxd_sync <= 1'b1;
            rxd_prev <= 1'b1;
        end else begin
            rxd_meta <= rxd;
            rxd_sync <= rxd_meta;
            rxd_prev <= rxd_sync;
        end
    end

    assign start_edge = rxd_prev && !rxd_sync;
    assign sample     = (state != ST_IDLE) && (tick_cnt == '0);
    assign rx_busy    = (state != ST_IDLE);

    always_ff @(posedge clk200 or negedge rst_n) begin
        if (!rst_n) begin
            state    <= ST_IDLE;
            tick_cnt <= '0;
            bit_idx  <= '0;
            rx_done  <= 1'b0;
            rx_word  <= '0;
        end else begin
            rx_done <= 1'b0;

            // Half a bit to the start sample, then full bits
            if (state == ST_IDLE) begin
                tick_cnt <= TICKS_HALF;
            end else if (sample) begin
                tick_cnt <= TICKS_FULL;
            end else begin
                tick_cnt <= tick_cnt - 1'b1;
            end

            case (state)
                ST_IDLE: begin
                    if (start_edge) begin
                        state <= ST_START;
                    end
                end
                ST_START: begin
                    if (sample) begin
                        // A line that is high again at mid-bit was only a glitch
                        state   <= rxd_sync ? ST_IDLE : ST_DATA;
                        bit_idx <= '0;
                    end
                end
                ST_DATA: begin
                    if (sample) begin
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == IDX_LAST) begin
                            state <= ST_STOP;
                        end
                    end
                end
                ST_STOP: begin
                    if (sample) begin
                        state             <= ST_IDLE;
                        rx_done           <= 1'b1;
                        rx_word.data      <= data_sr;
                        rx_word.frame_err <= (rxd_sync != uart_pkg::stop_bit);
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Data bits arrive LSB first, so shift in from the top
    always_ff @(posedge clk200) begin
        if (state == ST_DATA && sample) begin
            data_sr <= {rxd_sync, data_sr[uart_pkg::data_bits-1:1]};
        end
    end

    property p_done_single;
        @(posedge clk200) disable iff (!rst_n)
        rx_done |=> !rx_done;
    endproperty

    property p_done_after_busy;
        @(posedge clk200) disable iff (!rst_n)
        rx_done |-> $past(rx_busy);
    endproperty

    a_done_single : assert property (p_done_single)
        else $error("rx_done high on two consecutive cycles");

    a_done_after_busy : assert property (p_done_after_busy)
        else $error("rx_done without a frame in progress");

endmodule

`default_nettype wire

//--- logic/uart_core.sv
//**************************************************************************
// Serial link top. The transmitter runs from the shared strobe and the
// receiver keeps its own timing. No flow control, start pulses while busy
// are dropped.
//**************************************************************************

`timescale 1ns/1ps
`default_nettype none

module uart_core #(
    parameter int BIT_TICKS = uart_pkg::default_bit_ticks  // clk200 cycles per bit
) (
    input  logic               clk200,
    input  logic               rst_n,
    input  logic               tx_start,
    input  logic [7:0]         tx_data,
    output logic               tx_busy,
    output logic               txd,
    input  logic               rxd,
    output logic               rx_busy,
    output logic               rx_done,
    output uart_pkg::rx_word_t rx_word
);

    logic bit_strobe;

    baud_strobe #(
        .BIT_TICKS (BIT_TICKS)
    ) u_baud_strobe (
        .clk200     (clk200),
        .rst_n      (rst_n),
        .bit_strobe (bit_strobe)
    );

    uart_tx u_uart_tx (
        .clk200     (clk200),
        .rst_n      (rst_n),
        .bit_strobe (bit_strobe),
        .tx_start   (tx_start),
        .tx_data    (tx_data),
        .tx_busy    (tx_busy),
        .txd        (txd)
    );

    // Receiver samples on its own counter and does not use bit_strobe
    uart_rx #(
        .BIT_TICKS (BIT_TICKS)
    ) u_uart_rx (
        .clk200  (clk200),
        .rst_n   (rst_n),
        .rxd     (rxd),
        .rx_busy (rx_busy),
        .rx_done (rx_done),
        .rx_word (rx_word)
    );

endmodule

`default_nettype wire

//--- sim/uart_checker.sv
//**************************************************************************
// Watches the link and compares each received frame with a queue of
// expected words. Loopback bytes are queued only while loopback is set.
//**************************************************************************

`timescale 1ns/1ps
`default_nettype none

module uart_checker (
    input  logic               clk200,
    input  logic               rst_n,
    input  logic               tx_start,
    input  logic [7:0]         tx_data,
    input  logic               tx_busy,
    input  logic               txd,
    input  logic               rx_busy,
    input  logic               rx_done,
    input  uart_pkg::rx_word_t rx_word,
    input  logic               loopback,
    input  logic               inj_valid,   // Testbench is about to bit-bang inj_word
    input  uart_pkg::rx_word_t inj_word,
    input  logic               test_end,
    input  logic [2:0]         test_id,
    input  logic               all_done,
    output logic [31:0]        err_cnt
);

    uart_pkg::rx_word_t exp_q[$];

    int   errors       = 0;
    int   test_base    = 0;   // Error count when the current test began
    int   test_frames  = 0;
    int   frames_total = 0;
    int   tests_run    = 0;
    int   tests_failed = 0;
    logic rst_seen     = 1'b0;  // Reset was already low at the previous edge

    assign err_cnt = errors;

    function automatic string test_name(input logic [2:0] id);
        case (id)
            3'd1:    return "random loopback";
            3'd2:    return "start while busy";
            3'd3:    return "line idle level";
            3'd4:    return "frame error";
            3'd5:    return "start glitch";
            3'd6:    return "reset mid-frame";
            default: return "unknown";
        endcase
    endfunction

    task automatic report_value(input string sig, input logic [7:0] exp_v,
                                input logic [7:0] got_v);
        $display("** Error at %0t ns: %s expected %02h, got %02h", $time, sig, exp_v, got_v);
        errors = errors + 1;
    endtask

    task automatic report_fault(input string what);
        $display("Failure at %0t ns: %s", $time, what);
        errors = errors + 1;
    endtask

    always @(posedge clk200) begin
        uart_pkg::rx_word_t new_word;
        uart_pkg::rx_word_t exp_word;
        if (!rst_n) begin
            exp_q.delete();  // Frames cut off by reset never arrive
            // At power-up the flops may only take their reset values on the first edge
            if (rst_seen) begin
                if (txd !== 1'b1) begin
                    report_value("txd in reset", 8'h1, {7'h0, txd});
                end
                if (tx_busy !== 1'b0) begin
                    report_value("tx_busy in reset", 8'h0, {7'h0, tx_busy});
                end
                if (rx_busy !== 1'b0) begin
                    report_value("rx_busy in reset", 8'h0, {7'h0, rx_busy});
                end
            end
            rst_seen = 1'b1;
        end else begin
            rst_seen = 1'b0;

            if (!tx_busy && txd !== 1'b1) begin
                report_value("txd while idle", 8'h1, {7'h0, txd});
            end

            // Accepted start, the same rule the transmitter is specified by
            if (loopback && tx_start && !tx_busy) begin
                new_word.data      = tx_data;
                new_word.frame_err = 1'b0;
                exp_q.push_back(new_word);
            end
            if (inj_valid) begin
                exp_q.push_back(inj_word);
            end

            if (rx_done) begin
                test_frames  = test_frames + 1;
                frames_total = frames_total + 1;
                if (exp_q.size() == 0) begin
                    report_fault("rx_done pulsed with no frame expected");
                end else begin
                    exp_word = exp_q.pop_front();
                    if (rx_word.data !== exp_word.data) begin
                        report_value("rx_word.data", exp_word.data, rx_word.data);
                    end
                    if (rx_word.frame_err !== exp_word.frame_err) begin
                        report_value("rx_word.frame_err", {7'h0, exp_word.frame_err},
                                     {7'h0, rx_word.frame_err});
                    end
                end
            end

            if (test_end) begin
                if (exp_q.size() != 0) begin
                    report_fault($sformatf("%0d expected frames never arrived", exp_q.size()));
                    exp_q.delete();
                end
                tests_run = tests_run + 1;
                if (errors != test_base) tests_failed = tests_failed + 1;
                $display("Test %0d %-18s %s  frames %0d  errors %0d", test_id, test_name(test_id),
                         (errors == test_base) ? "ok" : "failed", test_frames, errors - test_base);
                test_base   = errors;
                test_frames = 0;
            end

            if (all_done) begin
                $display("Summary: %0d tests, %0d failed, %0d frames received, %0d errors",
                         tests_run, tests_failed, frames_total, errors);
            end
        end
    end

endmodule

`default_nettype wire

//--- sim/uart_tb.sv
//**************************************************************************
// Link testbench with a short bit time of 16 cycles. rxd is either the
// DUT's own txd or a line bit-banged here. Random data from a fixed seed.
//**************************************************************************

`timescale 1ns/1ps
`default_nettype none

module uart_tb;

    localparam int BIT_TICKS  = 16;
    localparam int CLK_PERIOD = 20;
    localparam int N_LOOP     = 200;
    localparam int N_BUSY     = 20;
    localparam int N_INJ      = 16;
    localparam int N_GLITCH   = 8;

    // Every frame or glitch window fits in 12 bit times
    localparam int N_FRAMES    = N_LOOP + 2 * N_BUSY + 2 * N_INJ + N_GLITCH + 8;
    localparam int WATCHDOG_NS = (N_FRAMES * 12 + 150) * BIT_TICKS * CLK_PERIOD;

    logic               clk200;
    logic               rst_n;
    logic               tx_start;
    logic [7:0]         tx_data;
    logic               tx_busy;
    logic               txd;
    logic               rxd;
    logic               rx_busy;
    logic               rx_done;
    uart_pkg::rx_word_t rx_word;
    logic               loopback;
    logic               line_drv;   // Bit-banged line level
    logic               inj_valid;
    uart_pkg::rx_word_t inj_word;
    logic               test_end;
    logic [2:0]         test_id;
    logic               all_done;
    logic [31:0]        err_cnt;
    logic [31:0]        lfsr;

    assign rxd = loopback ? txd : line_drv;

    uart_core #(
        .BIT_TICKS (BIT_TICKS)
    ) u_uart_core (
        .clk200   (clk200),
        .rst_n    (rst_n),
        .tx_start (tx_start),
        .tx_data  (tx_data),
        .tx_busy  (tx_busy),
        .txd      (txd),
        .rxd      (rxd),
        .rx_busy  (rx_busy),
        .rx_done  (rx_done),
        .rx_word  (rx_word)
    );

    uart_checker u_uart_checker (
        .clk200    (clk200),
        .rst_n     (rst_n),
        .tx_start  (tx_start),
        .tx_data   (tx_data),
        .tx_busy   (tx_busy),
        .txd       (txd),
        .rx_busy   (rx_busy),
        .rx_done   (rx_done),
        .rx_word   (rx_word),
        .loopback  (loopback),
        .inj_valid (inj_valid),
        .inj_word  (inj_word),
        .test_end  (test_end),
        .test_id   (test_id),
        .all_done  (all_done),
        .err_cnt   (err_cnt)
    );

    initial begin
        clk200 = 1'b0;
        forever #(CLK_PERIOD / 2) clk200 = ~clk200;
    end

    // Galois form, taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [7:0] take_bits(input int n);
        logic [7:0] v;
        v = 8'h00;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v    = {v[6:0], lfsr[0]};
        end
        return v;
    endfunction

    task automatic pulse_start(input logic [7:0] b);
        @(posedge clk200);
        tx_start <= 1'b1;
        tx_data  <= b;
        @(posedge clk200);
        tx_start <= 1'b0;
    endtask

    // Waits for the transmitter to go idle, then an idle gap, then starts
    task automatic send_byte(input logic [7:0] b, input logic [7:0] gap);
        @(negedge clk200);
        while (tx_busy) @(negedge clk200);
        repeat (gap) @(posedge clk200);
        pulse_start(b);
    endtask

    task automatic send_line_frame(input logic [7:0] b, input logic stop);
        logic [9:0] frame;
        frame = {stop, b, 1'b0};
        @(posedge clk200);
        inj_valid          <= 1'b1;
        inj_word.data      <= b;
        inj_word.frame_err <= !stop;
        @(posedge clk200);
        inj_valid <= 1'b0;
        for (int i = 0; i < 10; i++) begin
            line_drv <= frame[i];
            repeat (BIT_TICKS) @(posedge clk200);
        end
        line_drv <= 1'b1;
        repeat (2 * BIT_TICKS) @(posedge clk200);
    endtask

    task automatic send_glitch(input int len);
        @(posedge clk200);
        line_drv <= 1'b0;
        repeat (len) @(posedge clk200);
        line_drv <= 1'b1;
        repeat (12 * BIT_TICKS) @(posedge clk200);  // Long enough for a whole frame
    endtask

    task automatic finish_test(input logic [2:0] id);
        @(negedge clk200);
        while (tx_busy || rx_busy) @(negedge clk200);
        repeat (2 * BIT_TICKS) @(posedge clk200);
        test_id  <= id;
        test_end <= 1'b1;
        @(posedge clk200);
        test_end <= 1'b0;
    endtask

    task automatic apply_reset();
        @(posedge clk200);
        rst_n <= 1'b0;
        repeat (2) @(posedge clk200);
        rst_n <= 1'b1;
    endtask

    initial begin
        lfsr      = 32'ha9de5222;
        rst_n     = 1'b0;
        tx_start  = 1'b0;
        tx_data   = 8'h00;
        loopback  = 1'b1;
        line_drv  = 1'b1;
        inj_valid = 1'b0;
        inj_word  = '0;
        test_end  = 1'b0;
        test_id   = 3'd0;
        all_done  = 1'b0;
        repeat (2) @(posedge clk200);
        rst_n <= 1'b1;

        for (int i = 0; i < N_LOOP; i++) begin
            send_byte(take_bits(8), take_bits(4));
        end
        finish_test(3'd1);

        // The second pulse lands well inside the frame just started
        for (int i = 0; i < N_BUSY; i++) begin
            send_byte(take_bits(8), take_bits(4));
            repeat (take_bits(3)) @(posedge clk200);
            pulse_start(take_bits(8));
        end
        finish_test(3'd2);

        apply_reset();
        repeat (4 * BIT_TICKS) @(posedge clk200);
        for (int i = 0; i < 4; i++) begin
            send_byte(take_bits(8), 8'd0);
        end
        finish_test(3'd3);

        @(posedge clk200);
        loopback <= 1'b0;
        for (int i = 0; i < N_INJ; i++) begin
            send_line_frame(take_bits(8), 1'b0);
            send_line_frame(take_bits(8), 1'b1);
        end
        finish_test(3'd4);

        for (int i = 0; i < N_GLITCH; i++) begin
            send_glitch(1 + int'(take_bits(2)));
        end
        finish_test(3'd5);

        @(posedge clk200);
        loopback <= 1'b1;
        send_byte(take_bits(8), 8'd0);
        repeat (5 * BIT_TICKS) @(posedge clk200);
        apply_reset();
        send_byte(take_bits(8), 8'd0);
        finish_test(3'd6);

        @(posedge clk200);
        all_done <= 1'b1;
        @(posedge clk200);
        all_done <= 1'b0;
        @(posedge clk200);
        if (err_cnt == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns before the tests finished", WATCHDOG_NS);
        $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
logic/uart_pkg.sv
logic/baud_strobe.sv
logic/uart_tx.sv
logic/uart_rx.sv
logic/uart_core.sv
sim/uart_checker.sv
sim/uart_tb.sv

//--- Makefile
TOP = uart_tb

.PHONY: all compile run clean

all: run

compile: obj_dir/V$(TOP)

obj_dir/V$(TOP): verilog.f logic/*.sv sim/*.sv
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f verilog.f -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	@grep -q '^TEST PASSED$$' sim.log

clean:
	rm -rf obj_dir sim.log
